/* ant_engine.f */
source/ant_world_pkg.sv
source/ant_bus_pkg.sv
source/dp_port.sv
source/ant_update_fsm.sv
source/ant_draw_fsm.sv
source/ant_controller.sv
source/ant_engine.sv
verif/dp_memory_model.sv
verif/ant_engine_tb.sv

/* source/ant_bus_pkg.sv */
`default_nettype none

package ant_bus_pkg;

    localparam int MEM_ADDR_WIDTH = 8;
    localparam int RESULT_WIDTH = 16;

    // Sized to carry a full pixel for draw instructions
    localparam int DP_DATA_WIDTH = 18;

    typedef enum logic [1:0] {
        DP_NOP      = 2'd0,
        DP_MEMREAD  = 2'd1,
        DP_MEMWRITE = 2'd2,
        DP_DRAW     = 2'd3
    } dp_opcode_e;

    // Instruction word as seen by the external datapath
    typedef struct packed {
        logic [DP_DATA_WIDTH-1:0]  data;
        logic [MEM_ADDR_WIDTH-1:0] addr;
        dp_opcode_e                opcode;
    } dp_instr_t;

    // Each ant owns a block of words in datapath memory
    localparam int ANT_RECORD_STRIDE = 4;

    // Word offset of each field inside an ant record
    typedef enum logic [1:0] {
        FIELD_X       = 2'd0,
        FIELD_Y       = 2'd1,
        FIELD_FITNESS = 2'd2
    } ant_field_e;

    // Internal request from a command machine to the datapath port
    typedef struct packed {
        logic      valid;
        dp_instr_t instr;
    } dp_req_t;

endpackage

`default_nettype wire

/* source/ant_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module ant_controller (
    input  logic                    clock,
    input  logic                    resetn,
    input  logic                    start,
    input  ant_world_pkg::ant_cmd_t cmd,
    output logic                    finished,
    output ant_world_pkg::ant_cmd_t cmd_q,
    output logic                    go_update,
    output logic                    go_draw,
    input  ant_bus_pkg::dp_req_t    update_req,
    input  ant_bus_pkg::dp_req_t    draw_req,
    input  logic                    update_done,
    input  logic                    draw_done,
    output ant_bus_pkg::dp_req_t    port_req,
    input  logic                    port_done,
    output logic                    update_dp_done,
    output logic                    draw_dp_done
);

    import ant_world_pkg::*;

    logic accept;
    logic sel_update;
    logic sel_done;

    // Commands are only taken while the engine is idle
    assign accept = start && finished;

    // Latched op decides which machine owns the datapath port
    assign sel_update = (cmd_q.op == ANT_OP_UPDATE);
    assign port_req = sel_update ? update_req : draw_req;
    assign update_dp_done = port_done && sel_update;
    assign draw_dp_done = port_done && !sel_update;
    assign sel_done = sel_update ? update_done : draw_done;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            finished <= 1'b1;
            cmd_q <= '0;
            go_update <= 1'b0;
            go_draw <= 1'b0;
        end else begin
            go_update <= accept && (cmd.op == ANT_OP_UPDATE);
            go_draw <= accept && (cmd.op == ANT_OP_DRAW);
            if (accept) begin
                cmd_q <= cmd;
                finished <= 1'b0;
            end else if (sel_done) begin
                finished <= 1'b1;
            end
        end
    end

    // Machines read cmd_q for the whole sequence
    a_cmd_stable : assert property (@(posedge clock) disable iff (!resetn)
        !finished |=> $stable(cmd_q))
        else $error("cmd_q changed while a command was running");

    a_update_owner : assert property (@(posedge clock) disable iff (!resetn)
        update_req.valid |-> sel_update)
        else $error("update machine requested the datapath during a draw");

    a_draw_owner : assert property (@(posedge clock) disable iff (!resetn)
        draw_req.valid |-> !sel_update)
        else $error("draw machine requested the datapath during an update");

endmodule

`default_nettype wire

/* source/ant_draw_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module ant_draw_fsm (
    input  logic                                 clock,
    input  logic                                 resetn,
    input  logic                                 go,
    input  ant_world_pkg::ant_cmd_t              cmd,
    output ant_bus_pkg::dp_req_t                 dp_req,
    input  logic                                 dp_done,
    input  logic [ant_bus_pkg::RESULT_WIDTH-1:0] dp_result,
    output logic                                 done
);

    import ant_world_pkg::*;
    import ant_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD_X,
        ST_LOAD_Y,
        ST_DRAW
    } state_e;

    state_e                          state;
    logic                            issue;
    logic [MEM_ADDR_WIDTH-1:0]       rec_base;
    logic [X_COORD_WIDTH-1:0]        org_x;
    logic [Y_COORD_WIDTH-1:0]        org_y;
    logic [$clog2(ANT_WIDTH)-1:0]    dx;
    logic [$clog2(ANT_HEIGHT)-1:0]   dy;
    logic                            last_pixel;
    pixel_t                          pix;

    assign rec_base = MEM_ADDR_WIDTH'(cmd.id * ANT_RECORD_STRIDE);
    assign last_pixel = (dx == ANT_WIDTH - 1) && (dy == ANT_HEIGHT - 1);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= ST_IDLE;
            issue <= 1'b0;
            done <= 1'b0;
            dx <= '0;
            dy <= '0;
        end else begin
            issue <= 1'b0;
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (go) begin
                        dx <= '0;
                        dy <= '0;
                        state <= ST_LOAD_X;
                        issue <= 1'b1;
                    end
                end
                ST_LOAD_X, ST_LOAD_Y: begin
                    if (dp_done) begin
                        state <= state_e'(state + 1'b1);
                        issue <= 1'b1;
                    end
                end
                ST_DRAW: begin
                    if (dp_done && last_pixel) begin
                        state <= ST_IDLE;
                        done <= 1'b1;
                    end else if (dp_done) begin
                        // Row-major walk, dx wraps into the next row
                        dx <= dx + 1'b1;
                        if (dx == ANT_WIDTH - 1) dy <= dy + 1'b1;
                        issue <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Sprite origin sits one pixel up and left of the ant position
    always_ff @(posedge clock) begin
        if (state == ST_LOAD_X && dp_done) org_x <= dp_result[X_COORD_WIDTH-1:0] - 1'b1;
        if (state == ST_LOAD_Y && dp_done) org_y <= dp_result[Y_COORD_WIDTH-1:0] - 1'b1;
    end

    always_comb begin
        pix.colour = COLOUR_ANT;
        pix.y = org_y + Y_COORD_WIDTH'(dy);
        pix.x = org_x + X_COORD_WIDTH'(dx);
        dp_req = '0;
        dp_req.valid = issue;
        case (state)
            ST_LOAD_X: begin
                dp_req.instr.opcode = DP_MEMREAD;
                dp_req.instr.addr = rec_base + MEM_ADDR_WIDTH'(FIELD_X);
            end
            ST_LOAD_Y: begin
                dp_req.instr.opcode = DP_MEMREAD;
                dp_req.instr.addr = rec_base + MEM_ADDR_WIDTH'(FIELD_Y);
            end
            // Draws carry the pixel in data with a zero address
            ST_DRAW: begin
                dp_req.instr.opcode = DP_DRAW;
                dp_req.instr.data = pix;
            end
            default: dp_req.instr.opcode = DP_NOP;
        endcase
    end

endmodule

`default_nettype wire

/* source/ant_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module ant_engine (
    input  logic                                    clock,
    input  logic                                    resetn,

    // Host command interface
    input  logic                                    start,
    input  ant_world_pkg::ant_cmd_t                 cmd,
    output logic                                    finished,

    // Datapath interface
    output logic                                    start_dp,
    output ant_bus_pkg::dp_instr_t                  instruction_dp,
    input  logic                                    finished_dp,
    input  logic [ant_bus_pkg::RESULT_WIDTH-1:0]    result_dp
);

    import ant_world_pkg::*;
    import ant_bus_pkg::*;

    ant_cmd_t                cmd_q;
    logic                    go_update;
    logic                    go_draw;
    dp_req_t                 update_req;
    dp_req_t                 draw_req;
    dp_req_t                 port_req;
    logic                    update_done;
    logic                    draw_done;
    logic                    port_done;
    logic                    update_dp_done;
    logic                    draw_dp_done;
    logic [RESULT_WIDTH-1:0] port_result;

    ant_controller u_controller (
        .clock          (clock),
        .resetn         (resetn),
        .start          (start),
        .cmd            (cmd),
        .finished       (finished),
        .cmd_q          (cmd_q),
        .go_update      (go_update),
        .go_draw        (go_draw),
        .update_req     (update_req),
        .draw_req       (draw_req),
        .update_done    (update_done),
        .draw_done      (draw_done),
        .port_req       (port_req),
        .port_done      (port_done),
        .update_dp_done (update_dp_done),
        .draw_dp_done   (draw_dp_done)
    );

    ant_update_fsm u_update (
        .clock     (clock),
        .resetn    (resetn),
        .go        (go_update),
        .cmd       (cmd_q),
        .dp_req    (update_req),
        .dp_done   (update_dp_done),
        .dp_result (port_result),
        .done      (update_done)
    );

    ant_draw_fsm u_draw (
        .clock     (clock),
        .resetn    (resetn),
        .go        (go_draw),
        .cmd       (cmd_q),
        .dp_req    (draw_req),
        .dp_done   (draw_dp_done),
        .dp_result (port_result),
        .done      (draw_done)
    );

    dp_port u_dp_port (
        .clock          (clock),
        .resetn         (resetn),
        .req            (port_req),
        .done           (port_done),
        .result         (port_result),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp)
    );

endmodule

`default_nettype wire

/* source/ant_update_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module ant_update_fsm (
    input  logic                                 clock,
    input  logic                                 resetn,
    input  logic                                 go,
    input  ant_world_pkg::ant_cmd_t              cmd,
    output ant_bus_pkg::dp_req_t                 dp_req,
    input  logic                                 dp_done,
    input  logic [ant_bus_pkg::RESULT_WIDTH-1:0] dp_result,
    output logic                                 done
);

    import ant_world_pkg::*;
    import ant_bus_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_X,
        ST_LOAD_Y,
        ST_LOAD_FIT,
        ST_MOVE,
        ST_STORE_X,
        ST_STORE_Y,
        ST_STORE_FIT
    } state_e;

    state_e                    state;
    logic                      issue;
    logic [MEM_ADDR_WIDTH-1:0] rec_base;
    logic [X_COORD_WIDTH-1:0]  x;
    logic [Y_COORD_WIDTH-1:0]  y;
    logic [FITNESS_WIDTH-1:0]  fitness;
    logic [X_COORD_WIDTH-1:0]  x_left;
    logic [X_COORD_WIDTH-1:0]  x_moved;
    logic [Y_COORD_WIDTH-1:0]  y_up;
    logic [Y_COORD_WIDTH-1:0]  y_moved;

    assign rec_base = MEM_ADDR_WIDTH'(cmd.id * ANT_RECORD_STRIDE);

    // Left before right and up before down, each clamped to keep the sprite on screen
    assign x_left = (cmd.move.left && x > ANT_WIDTH / 2) ? x - 1'b1 : x;
    assign x_moved = (cmd.move.right && x_left < SCREEN_WIDTH - ANT_WIDTH / 2 - 1)
                   ? x_left + 1'b1 : x_left;
    assign y_up = (cmd.move.up && y > ANT_HEIGHT / 2) ? y - 1'b1 : y;
    assign y_moved = (cmd.move.down && y_up < SCREEN_HEIGHT - ANT_HEIGHT / 2 - 1)
                   ? y_up + 1'b1 : y_up;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= ST_IDLE;
            issue <= 1'b0;
            done <= 1'b0;
        end else begin
            issue <= 1'b0;
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (go) begin
                        state <= ST_LOAD_X;
                        issue <= 1'b1;
                    end
                end
                ST_LOAD_X, ST_LOAD_Y, ST_STORE_X, ST_STORE_Y: begin
                    if (dp_done) begin
                        state <= state_e'(state + 1'b1);
                        issue <= 1'b1;
                    end
                end
                // No request for the move step
                ST_LOAD_FIT: if (dp_done) state <= ST_MOVE;
                ST_MOVE: begin
                    state <= ST_STORE_X;
                    issue <= 1'b1;
                end
                ST_STORE_FIT: begin
                    if (dp_done) begin
                        state <= ST_IDLE;
                        done <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Ant record working copy
    always_ff @(posedge clock) begin
        if (state == ST_LOAD_X && dp_done) x <= dp_result[X_COORD_WIDTH-1:0];
        if (state == ST_LOAD_Y && dp_done) y <= dp_result[Y_COORD_WIDTH-1:0];
        if (state == ST_LOAD_FIT && dp_done) fitness <= dp_result[FITNESS_WIDTH-1:0];
        if (state == ST_MOVE) begin
            x <= x_moved;
            y <= y_moved;
        end
    end

    always_comb begin
        dp_req = '0;
        dp_req.valid = issue;
        case (state)
            ST_LOAD_X, ST_LOAD_Y, ST_LOAD_FIT: dp_req.instr.opcode = DP_MEMREAD;
            ST_STORE_X, ST_STORE_Y, ST_STORE_FIT: dp_req.instr.opcode = DP_MEMWRITE;
            default: dp_req.instr.opcode = DP_NOP;
        endcase
        case (state)
            ST_LOAD_X, ST_STORE_X: begin
                dp_req.instr.addr = rec_base + MEM_ADDR_WIDTH'(FIELD_X);
                dp_req.instr.data = DP_DATA_WIDTH'(x);
            end
            ST_LOAD_Y, ST_STORE_Y: begin
                dp_req.instr.addr = rec_base + MEM_ADDR_WIDTH'(FIELD_Y);
                dp_req.instr.data = DP_DATA_WIDTH'(y);
            end
            ST_LOAD_FIT, ST_STORE_FIT: begin
                dp_req.instr.addr = rec_base + MEM_ADDR_WIDTH'(FIELD_FITNESS);
                dp_req.instr.data = DP_DATA_WIDTH'(fitness);
            end
            default: dp_req.instr.addr = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/ant_world_pkg.sv */
`default_nettype none

package ant_world_pkg;

    // Screen geometry in pixels
    localparam int X_COORD_WIDTH = 8;
    localparam int Y_COORD_WIDTH = 7;
    localparam int SCREEN_WIDTH = 160;
    localparam int SCREEN_HEIGHT = 120;

    // Ant sprite is a small square centred on the ant position
    localparam int ANT_WIDTH = 4;
    localparam int ANT_HEIGHT = 4;

    localparam int COLOUR_WIDTH = 3;
    localparam logic [COLOUR_WIDTH-1:0] COLOUR_ANT = 3'b110;

    localparam int FITNESS_WIDTH = 8;
    localparam int ANT_ID_WIDTH = 6;

    typedef enum logic {
        ANT_OP_UPDATE = 1'b0,
        ANT_OP_DRAW   = 1'b1
    } ant_op_e;

    // One step per requested direction, applied left, right, up, down
    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } move_req_t;

    typedef struct packed {
        ant_op_e                 op;
        logic [ANT_ID_WIDTH-1:0] id;
        move_req_t               move;
    } ant_cmd_t;

    typedef struct packed {
        logic [COLOUR_WIDTH-1:0]  colour;
        logic [Y_COORD_WIDTH-1:0] y;
        logic [X_COORD_WIDTH-1:0] x;
    } pixel_t;

endpackage

`default_nettype wire

/* source/dp_port.sv */
`timescale 1ns/10ps
`default_nettype none

module dp_port (
    input  logic                                 clock,
    input  logic                                 resetn,
    input  ant_bus_pkg::dp_req_t                 req,
    output logic                                 done,
    output logic [ant_bus_pkg::RESULT_WIDTH-1:0] result,
    output logic                                 start_dp,
    output ant_bus_pkg::dp_instr_t               instruction_dp,
    input  logic                                 finished_dp,
    input  logic [ant_bus_pkg::RESULT_WIDTH-1:0] result_dp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DELAY,
        ST_WAIT
    } state_e;

    state_e state;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= ST_IDLE;
            start_dp <= 1'b0;
            instruction_dp <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req.valid) begin
                        instruction_dp <= req.instr;
                        start_dp <= 1'b1;
                        state <= ST_START;
                    end
                end
                // start_dp stays up through the delay cycle
                ST_START: state <= ST_DELAY;
                ST_DELAY: begin
                    start_dp <= 1'b0;
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (finished_dp) begin
                        done <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Capture the datapath answer alongside the done pulse
    always_ff @(posedge clock) begin
        if (state == ST_WAIT && finished_dp) begin
            result <= result_dp;
        end
    end

    a_start_two_cycles : assert property (@(posedge clock) disable iff (!resetn)
        start_dp ##1 start_dp |=> !start_dp)
        else $error("start_dp held high for more than two cycles");

    a_req_when_idle : assert property (@(posedge clock) disable iff (!resetn)
        req.valid |-> state == ST_IDLE)
        else $error("datapath request while an instruction is outstanding");

endmodule

`default_nettype wire

/* verif/ant_engine_stim.txt */
// op id move x y fitness | update: exp_x exp_y exp_fitness
// draw: exp_first_pixel exp_last_pixel exp_draw_count (all hex)
0 00 8 32 3c a5 31 3c a5
0 01 4 32 3c 07 33 3c 07
0 02 2 50 28 11 50 27 11
0 03 1 50 28 22 50 29 22
0 04 8 02 14 33 02 14 33
0 05 4 9d 14 44 9d 14 44
0 06 2 0a 02 66 0a 02 66
0 07 1 0a 75 77 0a 75 77
0 08 c 02 32 55 03 32 55
0 09 c 9d 32 99 9d 32 99
0 0a f 32 3c 88 32 3c 88
1 0a 0 14 1e 00 31d13 32016 10
1 3f 0 02 02 00 30101 30404 10
1 00 0 9d 75 00 3749c 3779f 10

/* verif/ant_engine_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ant_engine_tb;

    import ant_world_pkg::*;
    import ant_bus_pkg::*;

    localparam int NUM_TESTS = 14;
    localparam int STIM_COLS = 9;
    localparam int CLOCK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int WAIT_LIMIT = 400;
    localparam int UPDATE_TXNS = 6;

    logic                    clock;
    logic                    resetn;
    logic                    start;
    ant_cmd_t                cmd;
    logic                    finished;
    logic                    start_dp;
    dp_instr_t               instruction_dp;
    logic                    finished_dp;
    logic [RESULT_WIDTH-1:0] result_dp;

    logic [31:0] stim [0:NUM_TESTS*STIM_COLS-1];
    int          errors;
    int          start_run;

    ant_engine DUT (
        .clock          (clock),
        .resetn         (resetn),
        .start          (start),
        .cmd            (cmd),
        .finished       (finished),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp)
    );

    dp_memory_model u_mem (
        .clock          (clock),
        .resetn         (resetn),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Budget of 40 datapath transactions of 10 cycles for every test
    initial begin
        #(NUM_TESTS * 40 * 10 * CLOCK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Regression failed");
        $finish;
    end

    // Every instruction holds start_dp for exactly two cycles
    always @(negedge clock) begin
        if (!resetn) begin
            start_run = 0;
        end else if (start_dp) begin
            start_run = start_run + 1;
        end else if (start_run != 0) begin
            if (start_run != 2) begin
                report_mismatch("start_dp high cycles", 2, start_run);
            end
            start_run = 0;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        errors++;
    endtask

    // Accept one command, then try a stray start while the engine is busy
    task automatic issue_command(input ant_cmd_t c);
        @(posedge clock);
        #DRIVE_DELAY;
        start = 1'b1;
        cmd = c;
        @(posedge clock);
        #DRIVE_DELAY;
        start = 1'b0;
        repeat (3) @(posedge clock);
        #DRIVE_DELAY;
        start = 1'b1;
        cmd = ant_cmd_t'({1'b1, 6'h3e, 4'hf});
        @(posedge clock);
        #DRIVE_DELAY;
        start = 1'b0;
    endtask

    task automatic wait_finished(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            ok = finished;
            cycles++;
        end
    endtask

    task automatic check_update(input int base, input logic [31:0] exp_x,
                                input logic [31:0] exp_y, input logic [31:0] exp_fit);
        if (u_mem.mem[base] !== exp_x) report_mismatch("memory x", exp_x, u_mem.mem[base]);
        if (u_mem.mem[base + 1] !== exp_y) begin
            report_mismatch("memory y", exp_y, u_mem.mem[base + 1]);
        end
        if (u_mem.mem[base + 2] !== exp_fit) begin
            report_mismatch("memory fitness", exp_fit, u_mem.mem[base + 2]);
        end
        if (u_mem.txn_count != UPDATE_TXNS) begin
            report_mismatch("update transactions", UPDATE_TXNS, u_mem.txn_count);
        end
    endtask

    task automatic check_draw(input logic [31:0] first, input logic [31:0] last,
                              input logic [31:0] count);
        int i;
        int logged;
        logged = (u_mem.draw_count < 32) ? u_mem.draw_count : 32;
        if (u_mem.draw_count != count) report_mismatch("draw count", count, u_mem.draw_count);
        if (u_mem.txn_count != count + 2) begin
            report_mismatch("draw transactions", count + 2, u_mem.txn_count);
        end
        if (logged > 0) begin
            if (u_mem.pixel_log[0] !== first) begin
                report_mismatch("first pixel", first, u_mem.pixel_log[0]);
            end
            if (u_mem.pixel_log[logged - 1] !== last) begin
                report_mismatch("last pixel", last, u_mem.pixel_log[logged - 1]);
            end
        end
        for (i = 0; i < logged; i++) begin
            if (u_mem.pixel_log[i].colour !== COLOUR_ANT) begin
                report_mismatch("pixel colour", COLOUR_ANT, u_mem.pixel_log[i].colour);
            end
        end
    endtask

    // Reads and writes must stay inside the record of the commanded ant
    task automatic check_accesses(input int base);
        int i;
        for (i = 0; i < u_mem.access_count && i < 64; i++) begin
            if (u_mem.access_addr[i] < base || u_mem.access_addr[i] > base + 2) begin
                $display("Access to address %0h outside the record at %0h", 
                         u_mem.access_addr[i], base);
                errors++;
            end
        end
    endtask

    initial begin
        int          t;
        int          c;
        int          base;
        int          errors_before;
        int          passed;
        int          failed;
        int          txns;
        bit          ok;
        logic [31:0] col [0:STIM_COLS-1];

        errors = 0;
        passed = 0;
        failed = 0;
        start_run = 0;
        ok = 1'b1;
        resetn = 1'b0;
        start = 1'b0;
        cmd = '0;
        // Columns: op id move x y fitness, then expected x y fitness or first last count
        $readmemh("verif/ant_engine_stim.txt", stim);

        repeat (4) @(posedge clock);
        #DRIVE_DELAY;
        resetn = 1'b1;
        @(negedge clock);
        if (finished !== 1'b1) report_mismatch("finished", 1, finished);
        if (start_dp !== 1'b0) report_mismatch("start_dp", 0, start_dp);
        if (instruction_dp !== '0) report_mismatch("instruction_dp", 0, instruction_dp);

        for (t = 0; t < NUM_TESTS && ok; t++) begin
            for (c = 0; c < STIM_COLS; c++) begin
                col[c] = stim[t * STIM_COLS + c];
            end
            base = col[1] * ANT_RECORD_STRIDE;
            errors_before = errors;
            u_mem.mem[base] = col[3][RESULT_WIDTH-1:0];
            u_mem.mem[base + 1] = col[4][RESULT_WIDTH-1:0];
            u_mem.mem[base + 2] = col[5][RESULT_WIDTH-1:0];
            u_mem.clear_logs();

            issue_command(ant_cmd_t'({col[0][0], col[1][5:0], col[2][3:0]}));
            wait_finished(ok);
            if (!ok) begin
                $display("Test %0d timed out waiting for finished", t);
                errors++;
            end else begin
                if (col[0][0]) check_draw(col[6], col[7], col[8]);
                else check_update(base, col[6], col[7], col[8]);
                check_accesses(base);
                // The stray start must not have queued a second command
                txns = u_mem.txn_count;
                repeat (3) @(negedge clock);
                if (finished !== 1'b1) report_mismatch("finished after command", 1, finished);
                if (u_mem.txn_count != txns) begin
                    $display("Datapath activity after the command completed");
                    errors++;
                end
            end

            if (errors == errors_before) begin
                passed++;
                $display("Test %0d %s ant %0d: pass", t, col[0][0] ? "draw" : "update", col[1]);
            end else begin
                failed++;
                $display("Test %0d %s ant %0d: FAIL", t, col[0][0] ? "draw" : "update", col[1]);
            end
        end

        $display("Tests %0d, passed %0d, failed %0d, errors %0d", t, passed, failed, errors);
        if (errors == 0 && passed == NUM_TESTS) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/dp_memory_model.sv */
`timescale 1ns/10ps
`default_nettype none

module dp_memory_model (
    input  logic                                 clock,
    input  logic                                 resetn,
    input  logic                                 start_dp,
    input  ant_bus_pkg::dp_instr_t               instruction_dp,
    output logic                                 finished_dp,
    output logic [ant_bus_pkg::RESULT_WIDTH-1:0] result_dp
);

    import ant_world_pkg::*;
    import ant_bus_pkg::*;

    localparam int DRIVE_DELAY = 2;
    localparam int ACCESS_LOG_SIZE = 64;
    localparam int PIXEL_LOG_SIZE = 32;

    logic [RESULT_WIDTH-1:0]   mem [0:255];
    logic [31:0]               lfsr;
    logic [MEM_ADDR_WIDTH-1:0] access_addr [0:ACCESS_LOG_SIZE-1];
    pixel_t                    pixel_log [0:PIXEL_LOG_SIZE-1];
    int                        access_count;
    int                        draw_count;
    int                        txn_count;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic clear_logs();
        access_count = 0;
        draw_count = 0;
        txn_count = 0;
    endtask

    initial begin
        finished_dp = 1'b0;
        result_dp = '0;
        lfsr = 32'hecd2;
        clear_logs();
        // Background pattern so stray reads return address dependent data
        for (int a = 0; a < 256; a++) begin
            mem[a] = RESULT_WIDTH'(a * 257) ^ 16'h5a3c;
        end
    end

    task automatic serve(input dp_instr_t instr);
        txn_count++;
        result_dp = '0;
        case (instr.opcode)
            DP_MEMREAD: begin
                result_dp = mem[instr.addr];
                if (access_count < ACCESS_LOG_SIZE) access_addr[access_count] = instr.addr;
                access_count++;
            end
            DP_MEMWRITE: begin
                mem[instr.addr] = instr.data[RESULT_WIDTH-1:0];
                if (access_count < ACCESS_LOG_SIZE) access_addr[access_count] = instr.addr;
                access_count++;
            end
            DP_DRAW: begin
                if (draw_count < PIXEL_LOG_SIZE) draw_count_store(instr.data);
                draw_count++;
            end
            default: result_dp = '0;
        endcase
    endtask

    task automatic draw_count_store(input logic [DP_DATA_WIDTH-1:0] data);
        pixel_log[draw_count] = pixel_t'(data);
    endtask

    // One instruction at a time, answered after 0 to 7 idle cycles
    always begin : serve_loop
        dp_instr_t  instr;
        logic [2:0] idle;
        @(negedge clock);
        if (resetn && start_dp) begin
            instr = instruction_dp;
            while (start_dp) @(negedge clock);
            for (int b = 0; b < 3; b++) begin
                lfsr = lfsr_step(lfsr);
                idle[b] = lfsr[0];
            end
            repeat (idle) @(posedge clock);
            @(posedge clock);
            #DRIVE_DELAY;
            serve(instr);
            finished_dp = 1'b1;
            @(posedge clock);
            #DRIVE_DELAY;
            finished_dp = 1'b0;
        end
    end

endmodule

`default_nettype wire
